// File: verilog.f
+incdir+logic
logic/rv_core_pkg.sv
logic/inst_decoder.sv
logic/alu_exec.sv
logic/reg_file.sv
logic/writeback_unit.sv
logic/rv_core_top.sv
tests/rv_core_tb.sv

// File: tests/rv_core_tb.sv
`include "rv_core_defines.svh"

module rv_core_tb import rv_core_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;
    localparam int RESET_CYCLES = 16;

    // what the model expects to see on the ports for one instruction
    typedef struct packed {
        logic      illegal;
        logic      wb_en;
        reg_addr_t rd;
        word_t     data;
    } expect_t;

    logic      clk;
    logic      rst;
    word_t     inst;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      illegal;

    // program image indexed by pc / 4
    word_t   prog [$];
    int      prog_len = 0;
    // shadow architectural state
    word_t   shadow_regs [32];
    word_t   shadow_pc;
    expect_t expected;
    int      retired = 0;
    int      reset_edges = 0;
    int      checks = 0;
    int      errors = 0;

    rv_core_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .illegal (illegal)
    );

    always #10 clk = ~clk;

    function automatic word_t encode_itype(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                           logic [11:0] imm);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic word_t encode_rtype(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                           reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic word_t encode_utype(logic [6:0] opc, reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t lcg_next(word_t state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // one of the four supported funct3 codes
    function automatic logic [2:0] pick_funct3(logic [1:0] sel);
        case (sel)
            2'd0:    return `F3_ADD;
            2'd1:    return `F3_XOR;
            2'd2:    return `F3_OR;
            default: return `F3_AND;
        endcase
    endfunction

    // ISA result of add, xor, or and and selected by funct3
    function automatic word_t apply_funct3(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            `F3_ADD: return a + b;
            `F3_XOR: return a ^ b;
            `F3_OR:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // reference model for one instruction against the shadow state
    function automatic expect_t model_step(word_t instr, word_t cur_pc);
        expect_t   e;
        logic [2:0] f3;
        word_t     a;
        word_t     b;
        word_t     imm_i;
        word_t     imm_u;
        logic      f3_ok;
        f3    = instr[14:12];
        a     = (instr[19:15] == 5'd0) ? 32'd0 : shadow_regs[instr[19:15]];
        b     = (instr[24:20] == 5'd0) ? 32'd0 : shadow_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_u = {instr[31:12], 12'h000};
        f3_ok = (f3 == `F3_ADD) || (f3 == `F3_XOR) || (f3 == `F3_OR) || (f3 == `F3_AND);
        e.illegal = 1'b1;
        e.data    = '0;
        e.rd      = instr[11:7];
        case (instr[6:0])
            `OPC_OP_IMM: begin
                e.illegal = !f3_ok;
                e.data    = apply_funct3(f3, a, imm_i);
            end
            `OPC_OP: begin
                if (instr[31:25] == 7'b0000000 && f3_ok) begin
                    e.illegal = 1'b0;
                    e.data    = apply_funct3(f3, a, b);
                end else if (instr[31:25] == `F7_SUB && f3 == `F3_ADD) begin
                    e.illegal = 1'b0;
                    e.data    = a - b;
                end
            end
            `OPC_LUI: begin
                e.illegal = 1'b0;
                e.data    = imm_u;
            end
            `OPC_AUIPC: begin
                e.illegal = 1'b0;
                e.data    = cur_pc + imm_u;
            end
            default: e.illegal = 1'b1;
        endcase
        // rd of zero never shows up as a write
        e.wb_en = !e.illegal && (e.rd != 5'd0);
        return e;
    endfunction

    task automatic report_mismatch(string field, word_t got, word_t want);
        errors++;
        $display("** Error at %0d ns: %s mismatch, got %h expected %h", $time, field, got, want);
    endtask

    task automatic add_directed;
        prog.push_back(encode_utype(`OPC_LUI, 5'd1, 20'h12345));
        prog.push_back(encode_utype(`OPC_AUIPC, 5'd2, 20'h00001));
        // negative immediate checks sign extension
        prog.push_back(encode_itype(`F3_ADD, 5'd3, 5'd0, 12'hFFB));
        prog.push_back(encode_itype(`F3_ADD, 5'd4, 5'd1, 12'h7FF));
        // chain of back-to-back dependencies
        prog.push_back(encode_rtype(7'b0000000, `F3_ADD, 5'd5, 5'd3, 5'd4));
        prog.push_back(encode_rtype(`F7_SUB, `F3_ADD, 5'd6, 5'd5, 5'd1));
        prog.push_back(encode_rtype(7'b0000000, `F3_XOR, 5'd7, 5'd6, 5'd2));
        prog.push_back(encode_rtype(7'b0000000, `F3_OR, 5'd8, 5'd7, 5'd3));
        prog.push_back(encode_rtype(7'b0000000, `F3_AND, 5'd9, 5'd8, 5'd1));
        prog.push_back(encode_itype(`F3_XOR, 5'd10, 5'd9, 12'hFFF));
        prog.push_back(encode_itype(`F3_OR, 5'd11, 5'd10, 12'h0F0));
        prog.push_back(encode_itype(`F3_AND, 5'd12, 5'd11, 12'h0FF));
        // x0 as target and then read back
        prog.push_back(encode_itype(`F3_ADD, 5'd0, 5'd1, 12'h005));
        prog.push_back(encode_utype(`OPC_LUI, 5'd0, 20'hFFFFF));
        prog.push_back(encode_rtype(7'b0000000, `F3_ADD, 5'd13, 5'd0, 5'd1));
        // illegal words zero, all ones, slli, mul, sub-coded xor and beq
        prog.push_back(32'h0000_0000);
        prog.push_back(32'hFFFF_FFFF);
        prog.push_back(encode_itype(3'b001, 5'd14, 5'd1, 12'h003));
        prog.push_back(encode_rtype(7'b0000001, `F3_ADD, 5'd15, 5'd1, 5'd2));
        prog.push_back(encode_rtype(`F7_SUB, `F3_XOR, 5'd15, 5'd1, 5'd2));
        prog.push_back(32'h0000_0063);
        prog.push_back(encode_utype(`OPC_AUIPC, 5'd14, 20'h00000));
    endtask

    task automatic add_random_stream(int count);
        word_t state;
        word_t r;
        word_t s;
        state = 32'd50;
        for (int k = 0; k < count; k++) begin
            state = lcg_next(state);
            r     = state;
            state = lcg_next(state);
            s     = state;
            // low registers only so reads hit recent writes
            case (r[31:29])
                3'd0, 3'd1, 3'd6:
                    prog.push_back(encode_itype(pick_funct3(r[23:22]), {1'b0, s[19:16]},
                                                {1'b0, s[15:12]}, s[31:20]));
                3'd2, 3'd3: begin
                    if (r[21] && r[20])
                        prog.push_back(encode_rtype(`F7_SUB, `F3_ADD, {1'b0, s[19:16]},
                                                    {1'b0, s[15:12]}, {1'b0, r[27:24]}));
                    else
                        prog.push_back(encode_rtype(7'b0000000, pick_funct3(r[23:22]),
                                                    {1'b0, s[19:16]}, {1'b0, s[15:12]},
                                                    {1'b0, r[27:24]}));
                end
                3'd4:    prog.push_back(encode_utype(`OPC_LUI, {1'b0, r[19:16]}, s[31:12]));
                3'd5:    prog.push_back(encode_utype(`OPC_AUIPC, {1'b0, r[19:16]}, s[31:12]));
                // raw word that is mostly not a supported encoding
                default: prog.push_back(s);
            endcase
        end
    endtask

    // reset filler alternates an illegal word with a write to x1
    // next instruction follows the pc with nops past the end
    always @(negedge clk) begin
        if (reset_edges < RESET_CYCLES)
            inst <= reset_edges[0] ? 32'hFFFF_FFFF : encode_itype(`F3_ADD, 5'd1, 5'd0, 12'h001);
        else if (!$isunknown(pc) && pc[31:2] < prog_len)
            inst <= prog[pc[31:2]];
        else
            inst <= NOP;
    end

    // compare on every rising edge and then step the model
    always @(posedge clk) begin
        checks++;
        if (rst) begin
            if (wb_en !== 1'b0)
                report_mismatch("wb_en in reset", wb_en, 0);
            if (illegal !== 1'b0)
                report_mismatch("illegal in reset", illegal, 0);
            if (reset_edges > 0 && pc !== `RESET_PC)
                report_mismatch("pc in reset", pc, `RESET_PC);
            reset_edges++;
            shadow_pc = `RESET_PC;
            for (int i = 0; i < 32; i++)
                shadow_regs[i] = '0;
        end else begin
            expected = model_step(inst, shadow_pc);
            if (pc !== shadow_pc)
                report_mismatch("pc", pc, shadow_pc);
            if (illegal !== expected.illegal)
                report_mismatch("illegal", illegal, expected.illegal);
            if (wb_en !== expected.wb_en)
                report_mismatch("wb_en", wb_en, expected.wb_en);
            // payload only means something with the strobe up
            if (expected.wb_en && wb_rd !== expected.rd)
                report_mismatch("wb_rd", wb_rd, expected.rd);
            if (expected.wb_en && wb_data !== expected.data)
                report_mismatch("wb_data", wb_data, expected.data);
            if (expected.wb_en)
                shadow_regs[expected.rd] = expected.data;
            shadow_pc = shadow_pc + 32'd4;
            retired++;
        end
    end

    // watchdog sized from reset, program length and some slack
    initial begin
        wait (prog_len > 0);
        #((RESET_CYCLES + prog_len + 20) * 20);
        $display("run timed out before all instructions were executed");
        $display("test failed");
        $finish;
    end

    initial begin
        clk  = 1'b0;
        rst  = 1'b1;
        inst = NOP;
        add_directed();
        add_random_stream(400);
        prog_len = prog.size();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait (retired >= prog_len);
        @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: logic/rv_core_top.sv
module rv_core_top import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     inst,
    output word_t     pc,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      illegal
);

    // decode bundle
    ctrl_t     ctrl;
    // register read data
    word_t     rs1_data;
    word_t     rs2_data;
    // execute result
    exec_res_t exec_res;
    // register file write port
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;

    // opcode and funct fields into control
    inst_decoder i_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    // two reads from the decoded rs fields
    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata)
    );

    // operand select and alu
    alu_exec i_alu_exec (
        .ctrl     (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .exec_res (exec_res)
    );

    // pc register, write strobe and reset-gated status
    writeback_unit i_writeback (
        .clk         (clk),
        .rst         (rst),
        .exec_res    (exec_res),
        .dec_illegal (ctrl.illegal),
        .pc          (pc),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

endmodule

// File: logic/writeback_unit.sv
`include "rv_core_defines.svh"

module writeback_unit import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  exec_res_t exec_res,
    input  logic      dec_illegal,
    output word_t     pc,
    output logic      we,
    output reg_addr_t waddr,
    output word_t     wdata,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      illegal
);

    // pc steps by 4 every cycle with no stalls or branches
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // write strobe held low through reset
    assign we    = exec_res.reg_write & ~rst;
    assign waddr = exec_res.rd;
    assign wdata = exec_res.result;

    // observation copy of the write port
    assign wb_en   = we;
    assign wb_rd   = waddr;
    assign wb_data = wdata;

    // same reset gating as the write strobe
    assign illegal = dec_illegal & ~rst;

    // fetch address stays word aligned
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

// File: logic/reg_file.sv
module reg_file import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    // x0 slot cleared by reset and skipped by the write guard
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads
    // x0 comes back from its cleared slot
    // new value visible the cycle after the write edge
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 survives writes aimed at it
    assert property (@(posedge clk) disable iff (rst)
        (we && waddr == '0) |=> (regs[0] == '0))
        else $error("x0 changed after a write to index 0");

endmodule

// File: logic/alu_exec.sv
module alu_exec import rv_core_pkg::*; (
    input  ctrl_t     ctrl,
    input  word_t     pc,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output exec_res_t exec_res
);

    word_t op_a;
    word_t op_b;
    word_t result;

    // operand a select
    // pc wins over zero, neither set means rs1
    always_comb begin
        if (ctrl.src_a_pc) begin
            op_a = pc;
        end else if (ctrl.src_a_zero) begin
            op_a = '0;
        end else begin
            op_a = rs1_data;
        end
    end

    // operand b select
    assign op_b = ctrl.src_b_imm ? ctrl.imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            // illegal slots land here
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // hand result and target to writeback
    assign exec_res.result    = result;
    assign exec_res.rd        = ctrl.rd;
    assign exec_res.reg_write = ctrl.reg_write;

endmodule

// File: logic/inst_decoder.sv
`include "rv_core_defines.svh"

module inst_decoder import rv_core_pkg::*; (
    input  word_t inst,
    output ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    inst_fmt_t  fmt;

    // fixed field positions
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];

    // format key from opcode alone
    always_comb begin
        case (opcode)
            `OPC_OP_IMM: fmt = `FMT_I;
            `OPC_OP:     fmt = `FMT_R;
            `OPC_LUI,
            `OPC_AUIPC:  fmt = `FMT_U;
            default:     fmt = `FMT_BAD;
        endcase
    end

    always_comb begin
        ctrl            = '0;
        ctrl.rd         = rd;
        ctrl.rs1        = inst[19:15];
        ctrl.rs2        = inst[24:20];
        // auipc adds to pc, lui adds to zero
        ctrl.src_a_pc   = (opcode == `OPC_AUIPC);
        ctrl.src_a_zero = (opcode == `OPC_LUI);
        // only R-type reads rs2
        ctrl.src_b_imm  = (fmt != `FMT_R);
        // harmless op for anything not decoded
        ctrl.alu_op     = ALU_PASS_B;
        case (fmt)
            `FMT_I: begin
                // 12-bit signed immediate
                ctrl.imm       = {{(`XLEN - 12){inst[31]}}, inst[31:20]};
                ctrl.reg_write = (rd != '0);
                case (funct3)
                    `F3_ADD: ctrl.alu_op = ALU_ADD;
                    `F3_XOR: ctrl.alu_op = ALU_XOR;
                    `F3_OR:  ctrl.alu_op = ALU_OR;
                    `F3_AND: ctrl.alu_op = ALU_AND;
                    default: begin
                        // shifts and compares not supported
                        ctrl.illegal   = 1'b1;
                        ctrl.reg_write = 1'b0;
                    end
                endcase
            end
            `FMT_R: begin
                ctrl.reg_write = (rd != '0);
                if (funct7 == `F7_BASE) begin
                    case (funct3)
                        `F3_ADD: ctrl.alu_op = ALU_ADD;
                        `F3_XOR: ctrl.alu_op = ALU_XOR;
                        `F3_OR:  ctrl.alu_op = ALU_OR;
                        `F3_AND: ctrl.alu_op = ALU_AND;
                        default: begin
                            ctrl.illegal   = 1'b1;
                            ctrl.reg_write = 1'b0;
                        end
                    endcase
                end else if (funct7 == `F7_SUB && funct3 == `F3_ADD) begin
                    ctrl.alu_op = ALU_SUB;
                end else begin
                    // sra, M extension and the like
                    ctrl.illegal   = 1'b1;
                    ctrl.reg_write = 1'b0;
                end
            end
            `FMT_U: begin
                // upper 20 bits, low 12 cleared
                ctrl.imm       = {inst[31:12], 12'h000};
                ctrl.alu_op    = ALU_ADD;
                ctrl.reg_write = (rd != '0);
            end
            default: begin
                ctrl.illegal   = 1'b1;
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

    // every illegal branch above has to drop the write too
    always_comb begin
        assert final (!(ctrl.illegal && ctrl.reg_write))
            else $error("decoder raised illegal together with reg_write");
    end

endmodule

// File: logic/rv_core_pkg.sv
package rv_core_pkg;

    // data, address and instruction word
    typedef logic [31:0] word_t;
    // register index
    typedef logic [4:0]  reg_addr_t;
    // decoded format key
    typedef logic [2:0]  inst_fmt_t;
    // alu operation select
    typedef logic [2:0]  alu_op_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD    = 3'd0;
    localparam alu_op_t ALU_SUB    = 3'd1;
    localparam alu_op_t ALU_XOR    = 3'd2;
    localparam alu_op_t ALU_OR     = 3'd3;
    localparam alu_op_t ALU_AND    = 3'd4;
    // operand b straight through
    localparam alu_op_t ALU_PASS_B = 3'd5;

    // decoder output bundle
    typedef struct packed {
        // result goes to rd
        logic      reg_write;
        // operand a is the pc (auipc)
        logic      src_a_pc;
        // operand a forced to zero (lui)
        logic      src_a_zero;
        // operand b is the immediate
        logic      src_b_imm;
        alu_op_t   alu_op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        // already sign extended or shifted into place
        word_t     imm;
        // unsupported encoding
        logic      illegal;
    } ctrl_t;

    // execute stage result toward writeback
    typedef struct packed {
        word_t     result;
        reg_addr_t rd;
        logic      reg_write;
    } exec_res_t;

endpackage

// File: logic/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// data path width
`define XLEN        32
// first fetch address after reset
`define RESET_PC    32'h0000_0000

// major opcodes in inst[6:0]
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

// funct3 codes shared by OP and OP-IMM
`define F3_ADD      3'b000
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 codes for R-type
`define F7_BASE     7'b0000000
`define F7_SUB      7'b0100000

// instruction format keys
`define FMT_I       3'b000
`define FMT_U       3'b010
`define FMT_R       3'b011
`define FMT_BAD     3'b111

`endif
